// File: common/classifier_pkg.sv
package classifier_pkg;

    // pixel, weight and bias width
    parameter int DATA_W = 8;

    // accumulator width, enough for 256 inputs of 8x8 bit products
    parameter int ACC_W = 24;

    // default layer shape
    parameter int N_IN_DEFAULT  = 16;
    parameter int N_OUT_DEFAULT = 10;

    // table address width, up to 4096 weights
    parameter int ADDR_W = 12;

    // target table of a host write
    typedef enum logic [1:0] {
        SEL_WEIGHT = 2'd0,
        SEL_BIAS   = 2'd1,
        SEL_INPUT  = 2'd2
    } table_sel_t;

endpackage

// File: common/host_cmd_pkg.sv
package host_cmd_pkg;

    // ascii command letters
    parameter logic [7:0] CMD_WEIGHT = 8'h57;
    parameter logic [7:0] CMD_BIAS   = 8'h42;
    parameter logic [7:0] CMD_INPUT  = 8'h58;

    // decoder states, one per table being loaded
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_WEIGHT = 2'd1,
        ST_BIAS   = 2'd2,
        ST_INPUT  = 2'd3
    } dec_state_t;

endpackage

// File: common/load_if.sv
interface load_if;

    // one-cycle strobe per table write
    logic                              wr_en;
    classifier_pkg::table_sel_t        wr_sel;
    logic [classifier_pkg::ADDR_W-1:0] wr_addr;
    logic [classifier_pkg::DATA_W-1:0] wr_data;

    // run request, comes with the last input write
    logic                              start;

    modport producer (
        output wr_en, wr_sel, wr_addr, wr_data, start
    );

    modport consumer (
        input wr_en, wr_sel, wr_addr, wr_data, start
    );

endinterface

// File: hdl/host_cmd_decoder.sv
module host_cmd_decoder #(
    parameter int N_IN  = classifier_pkg::N_IN_DEFAULT,
    parameter int N_OUT = classifier_pkg::N_OUT_DEFAULT
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rx_valid,
    input  logic [classifier_pkg::DATA_W-1:0] rx_data,
    input  logic                              busy,
    load_if.producer                          load
);

    localparam int AW = classifier_pkg::ADDR_W;

    // last address of each table
    localparam logic [AW-1:0] LAST_WEIGHT = AW'(N_IN * N_OUT - 1);
    localparam logic [AW-1:0] LAST_BIAS   = AW'(N_OUT - 1);
    localparam logic [AW-1:0] LAST_INPUT  = AW'(N_IN - 1);

    host_cmd_pkg::dec_state_t   state;
    logic [AW-1:0]              count;
    logic                       accept;
    logic                       last_byte;
    classifier_pkg::table_sel_t sel;

    // drop bytes while a run is requested or in progress
    assign accept = rx_valid && !busy && !load.start;

    always_comb begin
        case (state)
            host_cmd_pkg::ST_WEIGHT: begin
                sel       = classifier_pkg::SEL_WEIGHT;
                last_byte = (count == LAST_WEIGHT);
            end
            host_cmd_pkg::ST_BIAS: begin
                sel       = classifier_pkg::SEL_BIAS;
                last_byte = (count == LAST_BIAS);
            end
            host_cmd_pkg::ST_INPUT: begin
                sel       = classifier_pkg::SEL_INPUT;
                last_byte = (count == LAST_INPUT);
            end
            default: begin
                sel       = classifier_pkg::SEL_WEIGHT;
                last_byte = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= host_cmd_pkg::ST_IDLE;
            count      <= '0;
            load.wr_en <= 1'b0;
            load.start <= 1'b0;
        end else begin
            load.wr_en <= 1'b0;
            load.start <= 1'b0;
            if (accept) begin
                if (state == host_cmd_pkg::ST_IDLE) begin
                    count <= '0;
                    case (rx_data)
                        host_cmd_pkg::CMD_WEIGHT: state <= host_cmd_pkg::ST_WEIGHT;
                        host_cmd_pkg::CMD_BIAS:   state <= host_cmd_pkg::ST_BIAS;
                        host_cmd_pkg::CMD_INPUT:  state <= host_cmd_pkg::ST_INPUT;
                        default:                  state <= host_cmd_pkg::ST_IDLE;
                    endcase
                end else begin
                    load.wr_en <= 1'b1;
                    if (last_byte) begin
                        state      <= host_cmd_pkg::ST_IDLE;
                        count      <= '0;
                        // the final input byte kicks off the layer
                        load.start <= (state == host_cmd_pkg::ST_INPUT);
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            end
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (accept && state != host_cmd_pkg::ST_IDLE) begin
            load.wr_sel  <= sel;
            load.wr_addr <= count;
            load.wr_data <= rx_data;
        end
    end

    a_start_with_input_write: assert property (
        @(posedge clk) disable iff (reset)
        load.start |-> load.wr_en && load.wr_sel == classifier_pkg::SEL_INPUT
    ) else $error("start without input write");

endmodule

// File: fc_layer/fc_mac_engine.sv
module fc_mac_engine #(
    parameter int N_IN  = classifier_pkg::N_IN_DEFAULT,
    parameter int N_OUT = classifier_pkg::N_OUT_DEFAULT
) (
    input  logic                             clk,
    input  logic                             reset,
    load_if.consumer                         load,
    output logic                             busy,
    output logic                             score_valid,
    output logic [classifier_pkg::ACC_W-1:0] score
);

    localparam int DW    = classifier_pkg::DATA_W;
    localparam int AccW  = classifier_pkg::ACC_W;
    localparam int N_W   = N_IN * N_OUT;
    localparam int WA_W  = (N_W > 1) ? $clog2(N_W) : 1;
    localparam int IN_W  = (N_IN > 1) ? $clog2(N_IN) : 1;
    localparam int CLS_W = (N_OUT > 1) ? $clog2(N_OUT) : 1;

    logic [DW-1:0]    weight_mem [N_W];
    logic [DW-1:0]    input_mem  [N_IN];
    logic [IN_W-1:0]  in_idx;
    logic [CLS_W-1:0] cls_idx;
    logic [AccW-1:0]  acc;
    logic [AccW-1:0]  acc_next;
    logic [WA_W-1:0]  w_addr;
    logic [2*DW-1:0]  product;
    logic             running;
    logic             row_end;

    // weight and input tables
    always_ff @(posedge clk) begin
        if (load.wr_en && load.wr_sel == classifier_pkg::SEL_WEIGHT) begin
            weight_mem[load.wr_addr[WA_W-1:0]] <= load.wr_data;
        end
        if (load.wr_en && load.wr_sel == classifier_pkg::SEL_INPUT) begin
            input_mem[load.wr_addr[IN_W-1:0]] <= load.wr_data;
        end
    end

    // weights stored row by row, one row per class
    assign w_addr   = WA_W'(int'(cls_idx) * N_IN + int'(in_idx));
    assign product  = input_mem[in_idx] * weight_mem[w_addr];
    assign acc_next = acc + AccW'(product);
    assign row_end  = (in_idx == IN_W'(N_IN - 1));

    // stays high through the last score strobe
    assign busy = running || score_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running     <= 1'b0;
            in_idx      <= '0;
            cls_idx     <= '0;
            score_valid <= 1'b0;
        end else begin
            score_valid <= 1'b0;
            if (load.start) begin
                running <= 1'b1;
                in_idx  <= '0;
                cls_idx <= '0;
            end else if (running) begin
                if (row_end) begin
                    score_valid <= 1'b1;
                    in_idx      <= '0;
                    if (cls_idx == CLS_W'(N_OUT - 1)) begin
                        running <= 1'b0;
                        cls_idx <= '0;
                    end else begin
                        cls_idx <= cls_idx + 1'b1;
                    end
                end else begin
                    in_idx <= in_idx + 1'b1;
                end
            end
        end
    end

    // one MAC per cycle
    always_ff @(posedge clk) begin
        if (load.start) begin
            acc <= '0;
        end else if (running) begin
            if (row_end) begin
                score <= acc_next;
                acc   <= '0;
            end else begin
                acc <= acc_next;
            end
        end
    end

    a_no_table_write_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        (load.wr_en && load.wr_sel != classifier_pkg::SEL_BIAS) |-> !busy
    ) else $error("weight or input write during a run");

endmodule

// File: fc_layer/score_argmax.sv
module score_argmax #(
    parameter int N_IN  = classifier_pkg::N_IN_DEFAULT,
    parameter int N_OUT = classifier_pkg::N_OUT_DEFAULT
) (
    input  logic                             clk,
    input  logic                             reset,
    load_if.consumer                         load,
    input  logic                             score_valid,
    input  logic [classifier_pkg::ACC_W-1:0] score,
    output logic [3:0]                       answer,
    output logic                             number_valid
);

    localparam int DW    = classifier_pkg::DATA_W;
    localparam int AccW  = classifier_pkg::ACC_W;
    localparam int CLS_W = (N_OUT > 1) ? $clog2(N_OUT) : 1;

    logic [DW-1:0]    bias_mem [N_OUT];
    logic [CLS_W-1:0] cls_cnt;
    logic [AccW-1:0]  sum;
    logic [AccW-1:0]  best_sum;
    logic [CLS_W-1:0] best_cls;
    logic [CLS_W-1:0] win_cls;
    logic             take;
    logic             last_cls;

    always_ff @(posedge clk) begin
        if (load.wr_en && load.wr_sel == classifier_pkg::SEL_BIAS) begin
            bias_mem[load.wr_addr[CLS_W-1:0]] <= load.wr_data;
        end
    end

    // bias zero-extended
    assign sum = score + AccW'(bias_mem[cls_cnt]);

    // strictly greater, so ties keep the lower class
    assign take     = (cls_cnt == '0) || (sum > best_sum);
    assign win_cls  = take ? cls_cnt : best_cls;
    assign last_cls = (cls_cnt == CLS_W'(N_OUT - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cls_cnt      <= '0;
            answer       <= '0;
            number_valid <= 1'b0;
        end else if (load.start) begin
            cls_cnt      <= '0;
            answer       <= '0;
            number_valid <= 1'b0;
        end else if (score_valid) begin
            if (last_cls) begin
                cls_cnt      <= '0;
                answer       <= 4'(win_cls);
                number_valid <= 1'b1;
            end else begin
                cls_cnt <= cls_cnt + 1'b1;
            end
        end
    end

    // running maximum
    always_ff @(posedge clk) begin
        if (score_valid && take) begin
            best_sum <= sum;
            best_cls <= cls_cnt;
        end
    end

    a_no_score_after_result: assert property (
        @(posedge clk) disable iff (reset)
        score_valid |-> !number_valid
    ) else $error("score arrived after the result was posted");

endmodule

// File: hdl/digit_classifier_top.sv
module digit_classifier_top #(
    parameter int N_IN  = classifier_pkg::N_IN_DEFAULT,
    parameter int N_OUT = classifier_pkg::N_OUT_DEFAULT
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rx_valid,
    input  logic [classifier_pkg::DATA_W-1:0] rx_data,
    output logic [3:0]                        answer,
    output logic                              number_valid,
    output logic                              busy
);

    logic                             score_valid;
    logic [classifier_pkg::ACC_W-1:0] score;

    load_if load_bus ();

    host_cmd_decoder #(.N_IN(N_IN), .N_OUT(N_OUT)) u_decoder (
        .clk      (clk),
        .reset    (reset),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .busy     (busy),
        .load     (load_bus.producer)
    );

    fc_mac_engine #(.N_IN(N_IN), .N_OUT(N_OUT)) u_mac (
        .clk         (clk),
        .reset       (reset),
        .load        (load_bus.consumer),
        .busy        (busy),
        .score_valid (score_valid),
        .score       (score)
    );

    score_argmax #(.N_IN(N_IN), .N_OUT(N_OUT)) u_argmax (
        .clk          (clk),
        .reset        (reset),
        .load         (load_bus.consumer),
        .score_valid  (score_valid),
        .score        (score),
        .answer       (answer),
        .number_valid (number_valid)
    );

endmodule

// File: dv/tb_digit_classifier.sv
module tb_digit_classifier;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_IN  = classifier_pkg::N_IN_DEFAULT;
    localparam int N_OUT = classifier_pkg::N_OUT_DEFAULT;

    logic       clk;
    logic       reset;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic [3:0] answer;
    logic       number_valid;
    logic       busy;

    // stimulus lines, tag letter and value
    logic [7:0]  tags [$];
    int unsigned vals [$];

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd62;
    int unsigned limit_cycles = 0;
    logic        limit_ready = 1'b0;

    digit_classifier_top #(.N_IN(N_IN), .N_OUT(N_OUT)) DUT (
        .clk          (clk),
        .reset        (reset),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .answer       (answer),
        .number_valid (number_valid),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // one byte strobe, then 0 to 3 idle cycles
    task automatic send_byte(input logic [7:0] data);
        int gap;
        rx_valid = 1'b1;
        rx_data  = data;
        @(negedge clk);
        rx_valid  = 1'b0;
        lcg_state = lcg_step(lcg_state);
        gap       = int'(lcg_state[17:16]);
        repeat (gap) @(negedge clk);
    endtask

    task automatic check_result(input logic [3:0] expected);
        // number_valid of the previous run drops the cycle after start
        repeat (2) @(negedge clk);
        while (number_valid !== 1'b1) @(negedge clk);
        check_value("answer", {4'h0, expected}, {4'h0, answer});
    endtask

    // value layout: answer in bits 5:2, number_valid bit 1, busy bit 0
    task automatic check_idle(input logic [5:0] expected);
        repeat (2) @(negedge clk);
        check_value("answer", {4'h0, expected[5:2]}, {4'h0, answer});
        check_value("number_valid", {7'h0, expected[1]}, {7'h0, number_valid});
        check_value("busy", {7'h0, expected[0]}, {7'h0, busy});
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        int unsigned val;
        int unsigned bytes;
        int unsigned runs;
        bytes = 0;
        runs  = 0;
        fd    = $fopen("dv/digit_stim.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file dv/digit_stim.txt");
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h", tag, val);
                if (n == 2 && tag != "#") begin
                    if (tag == "S" || tag == "Z" || tag == "E" || tag == "N") begin
                        tags.push_back(tag);
                        vals.push_back(val);
                        if (tag == "S") bytes += 1;
                        if (tag == "Z") bytes += val;
                        if (tag == "E") runs += 1;
                    end else begin
                        $display("unknown tag %c in the stimulus file", tag);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        assert (tags.size() > 0) else begin
            $display("the stimulus file holds no commands");
            errors++;
        end
        // 4 cycles per byte and per line, a full layer pass per result
        limit_cycles = (bytes + tags.size()) * 4 + runs * (N_IN * N_OUT + 20) + 20;
    endtask

    // watchdog
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        reset    = 1'b1;
        read_stimulus();
        limit_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (tags[k]) begin
            case (tags[k])
                "S":     send_byte(vals[k][7:0]);
                "Z":     repeat (vals[k]) send_byte(8'h00);
                "E":     check_result(vals[k][3:0]);
                default: check_idle(vals[k][5:0]);
            endcase
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dv/digit_stim.txt
# columns: tag and hex value. S sends the byte, Z sends value zero bytes,
# E waits for number_valid and expects answer, N checks answer/number_valid/busy
N 00
# weights W, w[3][3] = 2 at 0x33 and w[7][7] = 3 at 0x77, all others zero
S 57
Z 33
S 02
Z 43
S 03
Z 28
# biases B, all zero
S 42
Z 0A
# x3 = 0x10, x7 = 0x08, scores 32 and 24, clear winner
S 58
Z 03
S 10
Z 03
S 08
Z 08
E 03
# x3 = 0x0C, x7 = 0x08, both 24, tie keeps the lower class
S 58
Z 03
S 0C
Z 03
S 08
Z 08
E 03
# bias 5 on class 7 only, same input, 29 beats 24
S 42
Z 07
S 05
Z 02
S 58
Z 03
S 0C
Z 03
S 08
Z 08
E 07
# new run, result cleared and busy, stray X and 0x3F dropped
S 58
Z 03
S 10
Z 03
S 08
Z 08
N 01
S 58
S 3F
E 03
# decoder still idle after the dropped bytes
S 58
Z 03
S 0C
Z 03
S 08
Z 08
E 07

// File: sources.f
common/classifier_pkg.sv
common/host_cmd_pkg.sv
common/load_if.sv
hdl/host_cmd_decoder.sv
fc_layer/fc_mac_engine.sv
fc_layer/score_argmax.sv
hdl/digit_classifier_top.sv
dv/tb_digit_classifier.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_digit_classifier -f sources.f -o sim_digit_classifier || exit 1
out=$(./obj_dir/sim_digit_classifier)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
